//--- elem_unit.f
common/elem_pkg.sv
common/elem_stage_if.sv
hw/elem_ctrl/elem_ctrl.sv
hw/elem_datapath/elem_operand_shift.sv
hw/elem_datapath/elem_alu.sv
hw/elem_unit.sv
sim/elem_tb.sv

//--- Makefile
# Verilator build and run of the element unit testbench

VERILATOR ?= verilator
TOP       ?= elem_tb
FILELIST  ?= elem_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Finished with no errors

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/elem_tb.sv
/*
 * self-checking testbench for the vector element unit
 * register file model, reference model, result, latency and read address checks
 */

`timescale 1ns/10ps
`default_nettype none

module elem_tb;

    // 83 operations in total over all tests
    localparam int OP_COUNT       = 83;
    localparam int TIMEOUT_CYCLES = 40 * OP_COUNT + 100;

    logic                                 clk_i;
    logic                                 rst_ni;
    logic                                 op_rdy_i;
    logic                                 op_ack_o;
    elem_pkg::elem_op_e                   op_i;
    elem_pkg::elem_sew_e                  sew_i;
    logic [elem_pkg::VL_W-1:0]            vl_i;
    logic [elem_pkg::VREG_ADDR_W-1:0]     vs1_i;
    logic [elem_pkg::VREG_ADDR_W-1:0]     vs2_i;
    logic [elem_pkg::VREG_ADDR_W-1:0]     vreg_rd_addr_o;
    logic [elem_pkg::VREG_W-1:0]          vreg_rd_i;
    logic                                 xreg_valid_o;
    logic [elem_pkg::XLEN-1:0]            xreg_o;

    logic [elem_pkg::VREG_W-1:0]          regs [32];
    logic [elem_pkg::VREG_ADDR_W-1:0]     rd_addr_s;

    int seed = 82532;
    int cycle = 0;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int test_checks;
    int test_errors;
    string cur_test;

    // one entry per acknowledged operation
    logic [elem_pkg::XLEN-1:0] exp_q [$];
    int                        ack_q [$];
    int                        lat_q [$];
    string                     name_q [$];

    // register reads expected after the latest acknowledgement
    int                               rd_cyc = -1;
    string                            rd_name;
    logic [elem_pkg::VREG_ADDR_W-1:0] rd_vs1;
    logic [elem_pkg::VREG_ADDR_W-1:0] rd_vs2;

    // ack spacing of back-to-back operations
    logic chain_on = 1'b0;
    int   chain_ack = 0;
    int   chain_n = 0;

    elem_unit elem_unit_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .op_rdy_i       (op_rdy_i),
        .op_ack_o       (op_ack_o),
        .op_i           (op_i),
        .sew_i          (sew_i),
        .vl_i           (vl_i),
        .vs1_i          (vs1_i),
        .vs2_i          (vs2_i),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .vreg_rd_i      (vreg_rd_i),
        .xreg_valid_o   (xreg_valid_o),
        .xreg_o         (xreg_o)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) cycle <= cycle + 1;

    // register file answers the address of the previous cycle
    always @(negedge clk_i) rd_addr_s = vreg_rd_addr_o;

    always @(posedge clk_i) begin
        #1;
        vreg_rd_i = regs[rd_addr_s];
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    function automatic int elem_count(input elem_pkg::elem_sew_e sew);
        case (sew)
            elem_pkg::SEW_8:  return 16;
            elem_pkg::SEW_16: return 8;
            default:          return 4;
        endcase
    endfunction

    function automatic logic [elem_pkg::XLEN-1:0] elem_ref(
        input elem_pkg::elem_op_e          op,
        input elem_pkg::elem_sew_e         sew,
        input int                          vl,
        input logic [elem_pkg::VREG_W-1:0] v1,
        input logic [elem_pkg::VREG_W-1:0] v2
    );
        int                          esz;
        int                          n;
        int                          cnt;
        logic [31:0]                 mask;
        logic [31:0]                 acc;
        logic [31:0]                 a;
        logic [31:0]                 e;
        logic [31:0]                 r;
        logic signed [31:0]          sa;
        logic signed [31:0]          se;
        logic [elem_pkg::VREG_W-1:0] sh;
        esz  = 128 / elem_count(sew);
        n    = elem_count(sew);
        mask = (esz == 32) ? 32'hffff_ffff : ((32'd1 << esz) - 32'd1);
        if (op == elem_pkg::XMV) begin
            se = $signed((v2[31:0] & mask) << (32 - esz));
            se = se >>> (32 - esz);
            return se;
        end
        if (op == elem_pkg::VPOPC) begin
            cnt = 0;
            for (int i = 0; (i < n) && (i < vl); i++) begin
                cnt += int'(v2[i]);
            end
            return 32'(cnt);
        end
        acc = v1[31:0];
        for (int i = 0; (i < n) && (i < vl); i++) begin
            sh = v2 >> (i * esz);
            e  = sh[31:0] & mask;
            a  = acc & mask;
            se = $signed(e << (32 - esz));
            se = se >>> (32 - esz);
            sa = $signed(a << (32 - esz));
            sa = sa >>> (32 - esz);
            case (op)
                elem_pkg::VREDSUM:  r = a + e;
                elem_pkg::VREDAND:  r = a & e;
                elem_pkg::VREDOR:   r = a | e;
                elem_pkg::VREDXOR:  r = a ^ e;
                elem_pkg::VREDMINU: r = (e < a) ? e : a;
                elem_pkg::VREDMIN:  r = (se < sa) ? e : a;
                elem_pkg::VREDMAXU: r = (e > a) ? e : a;
                default:            r = (se > sa) ? e : a;
            endcase
            acc = (acc & ~mask) | (r & mask);
        end
        return acc;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checks

    task automatic check_xreg(input string name, input logic [elem_pkg::XLEN-1:0] exp,
                              input logic [elem_pkg::XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("error: %s cycles expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error: %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_rd_addr(input string name,
                                 input logic [elem_pkg::VREG_ADDR_W-1:0] exp,
                                 input logic [elem_pkg::VREG_ADDR_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error: %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    // results and register reads are compared first, then a newly acknowledged
    // operation is recorded
    always @(negedge clk_i) begin
        string nm;
        if (xreg_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("result strobe seen with no operation outstanding");
            end else begin
                nm = name_q.pop_front();
                check_xreg(nm, exp_q.pop_front(), xreg_o);
                check_latency({nm, " latency"}, lat_q.pop_front(), cycle - ack_q.pop_front());
            end
        end
        // vs2 is read in the cycle after the ack, vs1 in the cycle after that
        if (cycle == rd_cyc) begin
            check_rd_addr({rd_name, " vs2 read"}, rd_vs2, vreg_rd_addr_o);
        end else if (cycle == rd_cyc + 1) begin
            check_rd_addr({rd_name, " vs1 read"}, rd_vs1, vreg_rd_addr_o);
        end
        if (op_rdy_i && (op_ack_o === 1'b1)) begin
            nm = $sformatf("%s %s %s vl=%0d", cur_test, op_i.name(), sew_i.name(), vl_i);
            if (chain_on && (chain_n != 0)) begin
                check_latency({nm, " ack gap"}, chain_n + 1, cycle + 1 - chain_ack);
            end
            chain_ack = cycle + 1;
            chain_n   = elem_count(sew_i);
            rd_cyc    = cycle + 1;
            rd_name   = nm;
            rd_vs1    = vs1_i;
            rd_vs2    = vs2_i;
            exp_q.push_back(elem_ref(op_i, sew_i, int'(vl_i), regs[vs1_i], regs[vs2_i]));
            ack_q.push_back(cycle + 1);
            lat_q.push_back(elem_count(sew_i) + 3);
            name_q.push_back(nm);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    task automatic begin_test(input string name);
        cur_test    = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk_i);
        @(posedge clk_i);
        #1;
    endtask

    task automatic report_test();
        wait_drain();
        tests++;
        $display("test %s: %0d checks, %0d errors", cur_test,
                 checks - test_checks, errors - test_errors);
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the acknowledging edge
    task automatic issue_op(input elem_pkg::elem_op_e op, input elem_pkg::elem_sew_e sew,
                            input int vl, input int vs1, input int vs2);
        logic acked;
        op_rdy_i = 1'b1;
        op_i     = op;
        sew_i    = sew;
        vl_i     = 5'(vl);
        vs1_i    = 5'(vs1);
        vs2_i    = 5'(vs2);
        acked    = 1'b0;
        while (!acked) begin
            @(negedge clk_i);
            acked = op_ack_o;
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic run_single(input elem_pkg::elem_op_e op, input elem_pkg::elem_sew_e sew,
                              input int vl, input int vs1, input int vs2);
        issue_op(op, sew, vl, vs1, vs2);
        op_rdy_i = 1'b0;
        wait_drain();
    endtask

    task automatic check_idle();
        repeat (8) begin
            @(negedge clk_i);
            check_flag({cur_test, " op_ack_o"}, 1'b0, op_ack_o);
            check_flag({cur_test, " xreg_valid_o"}, 1'b0, xreg_valid_o);
        end
        @(posedge clk_i);
        #1;
    endtask

    initial begin
        elem_pkg::elem_sew_e sew;
        int                  n;
        clk_i     = 1'b0;
        rst_ni    = 1'b0;
        op_rdy_i  = 1'b0;
        op_i      = elem_pkg::XMV;
        sew_i     = elem_pkg::SEW_8;
        vl_i      = '0;
        vs1_i     = '0;
        vs2_i     = '0;
        vreg_rd_i = '0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        // negative and positive element 0 at every width
        regs[1][31:0] = 32'h8000_ff80;
        regs[2][31:0] = 32'h7fff_007f;

        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        begin_test("reset_idle");
        check_idle();
        report_test();

        begin_test("xmv");
        for (int s = 0; s < 3; s++) begin
            sew = elem_pkg::elem_sew_e'(2'(s));
            run_single(elem_pkg::XMV, sew, 0, 3, 1);
            run_single(elem_pkg::XMV, sew, 7, 3, 2);
        end
        report_test();

        begin_test("vpopc");
        for (int s = 0; s < 3; s++) begin
            sew = elem_pkg::elem_sew_e'(2'(s));
            n   = elem_count(sew);
            run_single(elem_pkg::VPOPC, sew, 0, 0, $random(seed) & 31);
            run_single(elem_pkg::VPOPC, sew, n / 2 + 1, 0, $random(seed) & 31);
            run_single(elem_pkg::VPOPC, sew, n + 3, 0, $random(seed) & 31);
        end
        report_test();

        begin_test("reductions");
        for (int s = 0; s < 3; s++) begin
            for (int k = 2; k <= 9; k++) begin
                repeat (2) begin
                    run_single(elem_pkg::elem_op_e'(4'(k)), elem_pkg::elem_sew_e'(2'(s)),
                               $random(seed) & 31, $random(seed) & 31, $random(seed) & 31);
                end
            end
        end
        report_test();

        begin_test("vl_zero");
        for (int k = 2; k <= 9; k++) begin
            run_single(elem_pkg::elem_op_e'(4'(k)), elem_pkg::elem_sew_e'(2'(k % 3)),
                       0, $random(seed) & 31, $random(seed) & 31);
        end
        report_test();

        // op_rdy_i stays high from one operation to the next
        begin_test("back_to_back");
        chain_n  = 0;
        chain_on = 1'b1;
        repeat (12) begin
            issue_op(elem_pkg::elem_op_e'(4'(($random(seed) & 32'h7fff_ffff) % 10)),
                     elem_pkg::elem_sew_e'(2'(($random(seed) & 32'h7fff_ffff) % 3)),
                     $random(seed) & 31, $random(seed) & 31, $random(seed) & 31);
        end
        op_rdy_i = 1'b0;
        report_test();
        chain_on = 1'b0;

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        while (cycle < TIMEOUT_CYCLES) @(posedge clk_i);
        $display("run timed out after %0d cycles", cycle);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/elem_unit.sv
/*
 * vector element unit top level
 * controller, operand shift stage and element ALU
 */

`timescale 1ns/10ps
`default_nettype none

module elem_unit (
    input  wire logic                                 clk_i,
    input  wire logic                                 rst_ni,

    // operation handshake
    input  wire logic                                 op_rdy_i,
    output      logic                                 op_ack_o,
    input  wire elem_pkg::elem_op_e                   op_i,
    input  wire elem_pkg::elem_sew_e                  sew_i,
    input  wire logic [elem_pkg::VL_W-1:0]            vl_i,
    input  wire logic [elem_pkg::VREG_ADDR_W-1:0]     vs1_i,
    input  wire logic [elem_pkg::VREG_ADDR_W-1:0]     vs2_i,

    // register file read port
    output      logic [elem_pkg::VREG_ADDR_W-1:0]     vreg_rd_addr_o,
    input  wire logic [elem_pkg::VREG_W-1:0]          vreg_rd_i,

    // scalar write-back to the core
    output      logic                                 xreg_valid_o,
    output      logic [elem_pkg::XLEN-1:0]            xreg_o
);

    // control aligned to read data, and its copy one stage later
    elem_stage_if ctrl_stage ();
    elem_stage_if alu_stage ();

    logic [elem_pkg::XLEN-1:0] elem;
    logic                      mask_bit;
    logic [elem_pkg::XLEN-1:0] init;

    elem_ctrl elem_ctrl_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .op_rdy_i       (op_rdy_i),
        .op_ack_o       (op_ack_o),
        .op_i           (op_i),
        .sew_i          (sew_i),
        .vl_i           (vl_i),
        .vs1_i          (vs1_i),
        .vs2_i          (vs2_i),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .stage_o        (ctrl_stage.ctrl_mp)
    );

    elem_operand_shift elem_operand_shift_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .stage_i    (ctrl_stage.dp_mp),
        .vreg_rd_i  (vreg_rd_i),
        .elem_o     (elem),
        .mask_bit_o (mask_bit),
        .init_o     (init),
        .stage_o    (alu_stage.ctrl_mp)
    );

    elem_alu elem_alu_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .stage_i      (alu_stage.dp_mp),
        .elem_i       (elem),
        .mask_bit_i   (mask_bit),
        .init_i       (init),
        .xreg_valid_o (xreg_valid_o),
        .xreg_o       (xreg_o)
    );

endmodule

`default_nettype wire

//--- hw/elem_datapath/elem_alu.sv
/*
 * element ALU with reduction accumulator and scalar result strobe
 */

`timescale 1ns/10ps
`default_nettype none

module elem_alu (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,

    elem_stage_if.dp_mp                       stage_i,
    input  wire logic [elem_pkg::XLEN-1:0]    elem_i,
    input  wire logic                         mask_bit_i,
    input  wire logic [elem_pkg::XLEN-1:0]    init_i,

    output      logic                         xreg_valid_o,
    output      logic [elem_pkg::XLEN-1:0]    xreg_o
);

    // extend the low element of v to one bit past XLEN
    function automatic logic signed [elem_pkg::XLEN:0] widen(
        input logic [elem_pkg::XLEN-1:0] v,
        input elem_pkg::elem_sew_e       sew,
        input logic                      sgn
    );
        logic [elem_pkg::XLEN:0] w;
        case (sew)
            elem_pkg::SEW_8:  w = {{(elem_pkg::XLEN-7){sgn & v[7]}}, v[7:0]};
            elem_pkg::SEW_16: w = {{(elem_pkg::XLEN-15){sgn & v[15]}}, v[15:0]};
            default:          w = {sgn & v[elem_pkg::XLEN-1], v};
        endcase
        return signed'(w);
    endfunction

    logic [elem_pkg::XLEN-1:0]   acc_q;
    logic [elem_pkg::XLEN-1:0]   acc_d;
    logic [elem_pkg::XLEN-1:0]   base;
    logic [elem_pkg::XLEN-1:0]   wmask;
    logic [elem_pkg::XLEN-1:0]   fold;
    logic signed [elem_pkg::XLEN:0] elem_w;
    logic signed [elem_pkg::XLEN:0] base_w;
    logic                        sgn;
    logic                        valid_q;

    ////////////////////////////////////////////////////////////////////////////
    // element operation

    always_comb begin
        // reductions start from the vs1 element
        base = stage_i.first ? init_i : acc_q;

        case (stage_i.sew)
            elem_pkg::SEW_8:  wmask = 32'h0000_00ff;
            elem_pkg::SEW_16: wmask = 32'h0000_ffff;
            default:          wmask = '1;
        endcase

        sgn = (stage_i.op == elem_pkg::XMV) |
              (stage_i.op == elem_pkg::VREDMIN) |
              (stage_i.op == elem_pkg::VREDMAX);
        elem_w = widen(elem_i, stage_i.sew, sgn);
        base_w = widen(base, stage_i.sew, sgn);

        case (stage_i.op)
            elem_pkg::VREDSUM:  fold = elem_i + base;
            elem_pkg::VREDAND:  fold = elem_i & base;
            elem_pkg::VREDOR:   fold = elem_i | base;
            elem_pkg::VREDXOR:  fold = elem_i ^ base;
            elem_pkg::VREDMINU,
            elem_pkg::VREDMIN:  fold = (elem_w < base_w) ? elem_i : base;
            elem_pkg::VREDMAXU,
            elem_pkg::VREDMAX:  fold = (elem_w > base_w) ? elem_i : base;
            default:            fold = base;
        endcase

        acc_d = base;
        case (stage_i.op)
            // sign-extended element 0, later elements leave it alone
            elem_pkg::XMV: begin
                acc_d = stage_i.first ? elem_w[elem_pkg::XLEN-1:0] : acc_q;
            end
            elem_pkg::VPOPC: begin
                acc_d = (stage_i.first ? '0 : acc_q) +
                        elem_pkg::XLEN'(mask_bit_i & stage_i.in_vl);
            end
            default: begin
                // upper bits stay as in the start value
                if (stage_i.in_vl) begin
                    acc_d = (base & ~wmask) | (fold & wmask);
                end
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // accumulator and result strobe

    always_ff @(posedge clk_i) begin
        if (stage_i.valid) begin
            acc_q <= acc_d;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= stage_i.valid & stage_i.last;
        end
    end

    assign xreg_valid_o = valid_q;
    assign xreg_o       = acc_q;

endmodule

`default_nettype wire

//--- hw/elem_datapath/elem_operand_shift.sv
/*
 * operand registers, shifting out one element or mask bit per cycle
 */

`timescale 1ns/10ps
`default_nettype none

module elem_operand_shift (
    input  wire logic                            clk_i,
    input  wire logic                            rst_ni,

    elem_stage_if.dp_mp                          stage_i,
    input  wire logic [elem_pkg::VREG_W-1:0]     vreg_rd_i,

    output      logic [elem_pkg::XLEN-1:0]       elem_o,
    output      logic                            mask_bit_o,
    output      logic [elem_pkg::XLEN-1:0]       init_o,

    elem_stage_if.ctrl_mp                        stage_o
);

    logic [elem_pkg::VREG_W-1:0] vec_q;
    logic [5:0]                  shamt;

    // mask ops walk bit by bit, everything else by element
    assign shamt = (stage_i.op == elem_pkg::VPOPC) ? 6'd1 : (6'd8 << stage_i.sew);

    always_ff @(posedge clk_i) begin
        if (stage_i.load_vec) begin
            vec_q <= vreg_rd_i;
        end else if (stage_i.valid) begin
            vec_q <= vec_q >> shamt;
        end
        if (stage_i.valid) begin
            elem_o     <= vec_q[elem_pkg::XLEN-1:0];
            mask_bit_o <= vec_q[0];
        end
        // only element 0 of the init register matters
        if (stage_i.load_init) begin
            init_o <= vreg_rd_i[elem_pkg::XLEN-1:0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // control copy for the ALU stage

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stage_o.valid     <= 1'b0;
            stage_o.first     <= 1'b0;
            stage_o.last      <= 1'b0;
            stage_o.load_vec  <= 1'b0;
            stage_o.load_init <= 1'b0;
        end else begin
            stage_o.valid     <= stage_i.valid;
            stage_o.first     <= stage_i.first;
            stage_o.last      <= stage_i.last;
            stage_o.load_vec  <= stage_i.load_vec;
            stage_o.load_init <= stage_i.load_init;
        end
    end

    always_ff @(posedge clk_i) begin
        stage_o.in_vl <= stage_i.in_vl;
        stage_o.op    <= stage_i.op;
        stage_o.sew   <= stage_i.sew;
    end

endmodule

`default_nettype wire

//--- hw/elem_ctrl/elem_ctrl.sv
/*
 * element unit controller: operation acceptance, element counter,
 * register read sequencing and per-element stage control
 */

`timescale 1ns/10ps
`default_nettype none

module elem_ctrl (
    input  wire logic                                 clk_i,
    input  wire logic                                 rst_ni,

    input  wire logic                                 op_rdy_i,
    output      logic                                 op_ack_o,
    input  wire elem_pkg::elem_op_e                   op_i,
    input  wire elem_pkg::elem_sew_e                  sew_i,
    input  wire logic [elem_pkg::VL_W-1:0]            vl_i,
    input  wire logic [elem_pkg::VREG_ADDR_W-1:0]     vs1_i,
    input  wire logic [elem_pkg::VREG_ADDR_W-1:0]     vs2_i,

    output      logic [elem_pkg::VREG_ADDR_W-1:0]     vreg_rd_addr_o,

    elem_stage_if.ctrl_mp                             stage_o
);

    ////////////////////////////////////////////////////////////////////////////
    // operation state

    logic                                 busy_q;
    logic                                 rd_vs2_q;   // vs2 read cycle
    logic [elem_pkg::ELEM_CNT_W-1:0]      count_q;    // byte index of the element

    elem_pkg::elem_op_e                   op_q;
    elem_pkg::elem_sew_e                  sew_q;
    logic [elem_pkg::VL_W-1:0]            vl_q;
    logic [elem_pkg::VREG_ADDR_W-1:0]     vs1_q;
    logic [elem_pkg::VREG_ADDR_W-1:0]     vs2_q;

    logic [elem_pkg::ELEM_CNT_W:0]        step;       // element size in bytes
    logic [elem_pkg::ELEM_CNT_W-1:0]      elem_idx;
    logic                                 elem_cyc;
    logic                                 elem_first;
    logic                                 elem_last;
    logic                                 accept;

    assign step     = {{elem_pkg::ELEM_CNT_W{1'b0}}, 1'b1} << sew_q;
    assign elem_idx = count_q >> sew_q;

    // element cycles follow the vs2 read, the first one also reads vs1
    assign elem_cyc   = busy_q & ~rd_vs2_q;
    assign elem_first = elem_cyc & (count_q == '0);
    assign elem_last  = elem_cyc &
        (({1'b0, count_q} + step) == (elem_pkg::ELEM_CNT_W+1)'(elem_pkg::VREG_BYTES));

    // take a new operation when idle or while the last element goes out
    assign accept   = op_rdy_i & (~busy_q | elem_last);
    assign op_ack_o = accept;

    assign vreg_rd_addr_o = rd_vs2_q ? vs2_q : vs1_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q   <= 1'b0;
            rd_vs2_q <= 1'b0;
            count_q  <= '0;
        end else if (accept) begin
            busy_q   <= 1'b1;
            rd_vs2_q <= 1'b1;
            count_q  <= '0;
        end else if (busy_q) begin
            rd_vs2_q <= 1'b0;
            if (elem_cyc) begin
                count_q <= count_q + step[elem_pkg::ELEM_CNT_W-1:0];
            end
            if (elem_last) begin
                busy_q <= 1'b0;
            end
        end
    end

    // operation fields, held for the whole operation
    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q  <= op_i;
            sew_q <= sew_i;
            vl_q  <= vl_i;
            vs1_q <= vs1_i;
            vs2_q <= vs2_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage control, one cycle later to meet the returning read data

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stage_o.valid     <= 1'b0;
            stage_o.first     <= 1'b0;
            stage_o.last      <= 1'b0;
            stage_o.load_vec  <= 1'b0;
            stage_o.load_init <= 1'b0;
        end else begin
            stage_o.valid     <= elem_cyc;
            stage_o.first     <= elem_first;
            stage_o.last      <= elem_last;
            stage_o.load_vec  <= busy_q & rd_vs2_q;
            stage_o.load_init <= elem_first;
        end
    end

    // vl is one bit wider than the element index
    always_ff @(posedge clk_i) begin
        stage_o.in_vl <= {1'b0, elem_idx} < vl_q;
        stage_o.op    <= op_q;
        stage_o.sew   <= sew_q;
    end

endmodule

`default_nettype wire

//--- common/elem_stage_if.sv
/*
 * per-element control passed between the pipeline stages
 */

`timescale 1ns/10ps
`default_nettype none

interface elem_stage_if;

    logic                 valid;      // an element is present
    logic                 first;
    logic                 last;
    logic                 load_vec;   // read data is the vector operand
    logic                 load_init;  // read data holds the reduction start value
    logic                 in_vl;      // element index below vl
    elem_pkg::elem_op_e   op;
    elem_pkg::elem_sew_e  sew;

    // producing stage
    modport ctrl_mp (
        output valid, first, last, load_vec, load_init, in_vl, op, sew
    );

    // consuming stage
    modport dp_mp (
        input  valid, first, last, load_vec, load_init, in_vl, op, sew
    );

endinterface

`default_nettype wire

//--- common/elem_pkg.sv
/*
 * shared widths, counts and the opcode and element width enums
 * of the vector element unit
 */

`default_nettype none

package elem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and counts

    // one vector register
    localparam int unsigned VREG_W      = 128;
    localparam int unsigned VREG_BYTES  = VREG_W / 8;

    // byte index into a vector register
    localparam int unsigned ELEM_CNT_W  = 4;

    // register file address
    localparam int unsigned VREG_ADDR_W = 5;

    // scalar result
    localparam int unsigned XLEN        = 32;

    // vector length, one more bit than the element index so vl = 16 fits
    localparam int unsigned VL_W        = 5;

    ////////////////////////////////////////////////////////////////////////////
    // opcodes

    typedef enum logic [3:0] {
        XMV      = 4'd0,
        VPOPC    = 4'd1,
        VREDSUM  = 4'd2,
        VREDAND  = 4'd3,
        VREDOR   = 4'd4,
        VREDXOR  = 4'd5,
        VREDMINU = 4'd6,
        VREDMIN  = 4'd7,
        VREDMAXU = 4'd8,
        VREDMAX  = 4'd9
    } elem_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // element widths

    // the encoding is log2 of the element size in bytes, so shifting
    // by the enum value gives the byte step and the bit step
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } elem_sew_e;

endpackage

`default_nettype wire
